// File: hw/rv_core_cfg.svh
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// Data path width, fixed by RV32I
`define RV_XLEN 32

// Architectural registers, x0 included
`define RV_NUM_REGS 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Hold the PC while an ECALL sits in fetch
`define RV_HALT_FREEZE 1

`endif

// File: hw/rv_pkg.sv
`include "rv_core_cfg.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0]              word_t;
  typedef logic [$clog2(`RV_NUM_REGS)-1:0]  reg_idx_t;
  typedef logic [`RV_XLEN/8-1:0]            byte_en_t;  // One bit per byte lane
  typedef logic [2:0]                       funct3_t;

  // Major opcodes, insn[6:0]
  typedef enum logic [6:0] {
    OP_LOAD     = 7'b00_000_11,
    OP_STORE    = 7'b01_000_11,
    OP_BRANCH   = 7'b11_000_11,
    OP_JALR     = 7'b11_001_11,
    OP_MISC_MEM = 7'b00_011_11,
    OP_JAL      = 7'b11_011_11,
    OP_IMM      = 7'b00_100_11,
    OP_REG      = 7'b01_100_11,
    OP_SYSTEM   = 7'b11_100_11,
    OP_AUIPC    = 7'b00_101_11,
    OP_LUI      = 7'b01_101_11
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // LUI
  } alu_op_e;

  // Register writeback source
  typedef enum logic [1:0] {
    WB_ALU,
    WB_LOAD,
    WB_PC4
  } wb_sel_e;

endpackage

// File: hw/rv_regfile.sv
`timescale 1ns/100ps

`include "rv_core_cfg.svh"

module rv_regfile (
  input  logic             clk,
  input  logic             rst,
  input  logic             we,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    rd_data,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data
);
  import rv_pkg::*;

  word_t regs [1:`RV_NUM_REGS-1]; // x0 has no storage

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

  // Combinational reads, x0 reads as zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // Written value reads back on the next cycle and x0 stays zero
  assert property (@(posedge clk) disable iff (rst)
    we |=> (rs1 != $past(rd) ||
            rs1_data == (($past(rd) == '0) ? word_t'(0) : $past(rd_data))))
    else $error("Register read back differs from the last write");

endmodule

// File: hw/rv_decoder.sv
`timescale 1ns/100ps

module rv_decoder (
  input  rv_pkg::word_t    insn,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  output rv_pkg::reg_idx_t rd,
  output rv_pkg::word_t    imm,
  output rv_pkg::funct3_t  funct3,
  output rv_pkg::alu_op_e  alu_op,
  output logic             src_a_pc,
  output logic             src_b_imm,
  output logic             reg_we,
  output logic             mem_read,
  output logic             mem_write,
  output logic             is_branch,
  output logic             is_jal,
  output logic             is_jalr,
  output logic             is_ecall,
  output rv_pkg::wb_sel_e  wb_sel
);
  import rv_pkg::*;

  opcode_e opcode;
  logic    alt_op;   // insn[30], picks SUB and SRA
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_b;
  word_t   imm_j;
  word_t   imm_u;
  alu_op_e funct_op; // Operation named by funct3/funct7

  assign opcode = opcode_e'(insn[6:0]);
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign alt_op = insn[30];

  // Sign-extended immediates for every format
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  always_comb begin
    case (funct3)
      3'b000:  funct_op = (opcode == OP_REG && alt_op) ? ALU_SUB : ALU_ADD; // No SUBI
      3'b001:  funct_op = ALU_SLL;
      3'b010:  funct_op = ALU_SLT;
      3'b011:  funct_op = ALU_SLTU;
      3'b100:  funct_op = ALU_XOR;
      3'b101:  funct_op = alt_op ? ALU_SRA : ALU_SRL;
      3'b110:  funct_op = ALU_OR;
      default: funct_op = ALU_AND;
    endcase
  end

  always_comb begin
    imm       = imm_i;
    alu_op    = ALU_ADD;
    src_a_pc  = 1'b0;
    src_b_imm = 1'b0;
    reg_we    = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    is_branch = 1'b0;
    is_jal    = 1'b0;
    is_jalr   = 1'b0;
    is_ecall  = 1'b0;
    wb_sel    = WB_ALU;
    case (opcode)
      OP_LUI: begin
        imm       = imm_u;
        alu_op    = ALU_PASS_B;
        src_b_imm = 1'b1;
        reg_we    = 1'b1;
      end
      OP_AUIPC: begin
        imm       = imm_u;
        src_a_pc  = 1'b1;
        src_b_imm = 1'b1;
        reg_we    = 1'b1;
      end
      OP_JAL: begin
        imm    = imm_j;
        is_jal = 1'b1;
        reg_we = 1'b1;
        wb_sel = WB_PC4;
      end
      OP_JALR: begin
        // ALU adds rs1 + imm for the target
        src_b_imm = 1'b1;
        is_jalr   = 1'b1;
        reg_we    = 1'b1;
        wb_sel    = WB_PC4;
      end
      OP_BRANCH: begin
        imm       = imm_b;
        is_branch = 1'b1;
      end
      OP_LOAD: begin
        mem_read = 1'b1;
        reg_we   = 1'b1;
        wb_sel   = WB_LOAD;
      end
      OP_STORE: begin
        imm       = imm_s;
        mem_write = 1'b1;
      end
      OP_IMM: begin
        alu_op    = funct_op;
        src_b_imm = 1'b1;
        reg_we    = 1'b1;
      end
      OP_REG: begin
        alu_op = funct_op;
        reg_we = 1'b1;
      end
      OP_SYSTEM: is_ecall = (insn[31:7] == '0);
      default: ; // FENCE and unknown opcodes retire as no-ops
    endcase
  end

endmodule

// File: hw/rv_alu.sv
`timescale 1ns/100ps

module rv_alu (
  input  rv_pkg::alu_op_e op,
  input  rv_pkg::word_t   a,
  input  rv_pkg::word_t   b,
  input  rv_pkg::word_t   rs1_data,
  input  rv_pkg::word_t   rs2_data,
  input  rv_pkg::funct3_t funct3,
  output rv_pkg::word_t   result,
  output logic            branch_cond
);
  import rv_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0]; // Upper bits of b ignored for shifts

  always_comb begin
    case (op)
      ALU_ADD:    result = a + b;
      ALU_SUB:    result = a - b;
      ALU_SLL:    result = a << shamt;
      ALU_SLT:    result = word_t'($signed(a) < $signed(b));
      ALU_SLTU:   result = word_t'(a < b);
      ALU_XOR:    result = a ^ b;
      ALU_SRL:    result = a >> shamt;
      ALU_SRA:    result = word_t'($signed(a) >>> shamt);
      ALU_OR:     result = a | b;
      ALU_AND:    result = a & b;
      ALU_PASS_B: result = b;
      default:    result = '0;
    endcase
  end

  // Branch relation on the raw register values
  always_comb begin
    case (funct3)
      3'b000:  branch_cond = (rs1_data == rs2_data);                  // BEQ
      3'b001:  branch_cond = (rs1_data != rs2_data);                  // BNE
      3'b100:  branch_cond = ($signed(rs1_data) < $signed(rs2_data));  // BLT
      3'b101:  branch_cond = ($signed(rs1_data) >= $signed(rs2_data)); // BGE
      3'b110:  branch_cond = (rs1_data < rs2_data);                   // BLTU
      3'b111:  branch_cond = (rs1_data >= rs2_data);                  // BGEU
      default: branch_cond = 1'b0;
    endcase
  end

endmodule

// File: hw/rv_lsu.sv
`timescale 1ns/100ps

module rv_lsu (
  input  rv_pkg::word_t    base,
  input  rv_pkg::word_t    offset,
  input  rv_pkg::word_t    store_src,
  input  rv_pkg::word_t    dmem_rdata,
  input  rv_pkg::funct3_t  funct3,
  input  logic             mem_write,
  input  logic             mem_read,
  output rv_pkg::word_t    dmem_addr,
  output rv_pkg::word_t    dmem_wdata,
  output rv_pkg::word_t    load_data,
  output rv_pkg::byte_en_t dmem_be
);
  import rv_pkg::*;

  word_t       addr;
  logic [1:0]  lane;    // Byte offset within the word
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  assign addr      = base + offset;
  assign lane      = addr[1:0];
  assign dmem_addr = {addr[31:2], 2'b00};

  // Stores replicate the data into every lane, enables pick the target
  always_comb begin
    case (funct3[1:0])
      2'b00: begin
        dmem_wdata = {4{store_src[7:0]}};
        dmem_be    = 4'b0001 << lane;
      end
      2'b01: begin
        dmem_wdata = {2{store_src[15:0]}};
        dmem_be    = lane[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        dmem_wdata = store_src;
        dmem_be    = 4'b1111;
      end
    endcase
    if (!mem_write) begin
      dmem_be = '0;
    end
  end

  always_comb begin
    ld_byte = dmem_rdata[{lane, 3'b000} +: 8];
    ld_half = lane[1] ? dmem_rdata[31:16] : dmem_rdata[15:0];
    case (funct3)
      3'b000:  load_data = {{24{ld_byte[7]}}, ld_byte};  // LB
      3'b001:  load_data = {{16{ld_half[15]}}, ld_half}; // LH
      3'b100:  load_data = {24'b0, ld_byte};             // LBU
      3'b101:  load_data = {16'b0, ld_half};             // LHU
      default: load_data = dmem_rdata;
    endcase
    if (!mem_read) begin
      load_data = '0;
    end
  end

endmodule

// File: hw/rv_core.sv
`timescale 1ns/100ps

`include "rv_core_cfg.svh"

module rv_core (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::word_t    imem_data,
  input  rv_pkg::word_t    dmem_rdata,
  output rv_pkg::word_t    imem_addr,
  output rv_pkg::word_t    dmem_addr,
  output rv_pkg::word_t    dmem_wdata,
  output rv_pkg::byte_en_t dmem_be,
  output logic             halt
);
  import rv_pkg::*;

  word_t    pc;
  word_t    pc_next;
  word_t    pc_plus4;
  word_t    pc_target; // Branch and JAL destination
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t    imm;
  funct3_t  funct3;
  alu_op_e  alu_op;
  wb_sel_e  wb_sel;
  logic     src_a_pc;
  logic     src_b_imm;
  logic     reg_we;
  logic     mem_read;
  logic     mem_write;
  logic     is_branch;
  logic     is_jal;
  logic     is_jalr;
  logic     is_ecall;
  logic     branch_cond;
  logic     rf_we;
  logic     store_en;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    alu_a;
  word_t    alu_b;
  word_t    alu_result;
  word_t    load_data;
  word_t    rd_data;

  assign halt      = is_ecall && !rst;
  assign rf_we     = reg_we && !halt && !rst;
  assign store_en  = mem_write && !halt && !rst;
  assign imem_addr = rst ? `RV_RESET_PC : pc; // Reset PC visible while rst is high

  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + imm;

  always_comb begin
    if (halt && (`RV_HALT_FREEZE != 0)) begin
      pc_next = pc;
    end else if (is_jalr) begin
      pc_next = {alu_result[31:1], 1'b0};
    end else if (is_jal || (is_branch && branch_cond)) begin
      pc_next = pc_target;
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RV_RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  assign alu_a = src_a_pc ? pc : rs1_data;  // AUIPC uses the PC
  assign alu_b = src_b_imm ? imm : rs2_data;

  always_comb begin
    case (wb_sel)
      WB_LOAD: rd_data = load_data;
      WB_PC4:  rd_data = pc_plus4;  // Link address
      default: rd_data = alu_result;
    endcase
  end

  rv_decoder u_decoder (
    .insn      (imem_data),
    .rs1       (rs1),
    .rs2       (rs2),
    .rd        (rd),
    .imm       (imm),
    .funct3    (funct3),
    .alu_op    (alu_op),
    .src_a_pc  (src_a_pc),
    .src_b_imm (src_b_imm),
    .reg_we    (reg_we),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .is_branch (is_branch),
    .is_jal    (is_jal),
    .is_jalr   (is_jalr),
    .is_ecall  (is_ecall),
    .wb_sel    (wb_sel)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .we       (rf_we),
    .rs1      (rs1),
    .rs2      (rs2),
    .rd       (rd),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rv_alu u_alu (
    .op          (alu_op),
    .a           (alu_a),
    .b           (alu_b),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .funct3      (funct3),
    .result      (alu_result),
    .branch_cond (branch_cond)
  );

  rv_lsu u_lsu (
    .base       (rs1_data),
    .offset     (imm),
    .store_src  (rs2_data),
    .dmem_rdata (dmem_rdata),
    .funct3     (funct3),
    .mem_write  (store_en),
    .mem_read   (mem_read),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .load_data  (load_data),
    .dmem_be    (dmem_be)
  );

  // Jump and branch targets never break word alignment
  assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
    else $error("PC misaligned: %h", pc);

endmodule

// File: verif/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

function automatic word_t enc_r(funct3_t f3, logic alt, reg_idx_t rd, reg_idx_t rs1,
                                reg_idx_t rs2);
  return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP_REG};
endfunction

function automatic word_t enc_i(opcode_e op, funct3_t f3, reg_idx_t rd, reg_idx_t rs1,
                                logic [11:0] imm);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic word_t enc_s(funct3_t f3, reg_idx_t rs1, reg_idx_t rs2, logic [11:0] imm);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
endfunction

function automatic word_t enc_b(funct3_t f3, reg_idx_t rs1, reg_idx_t rs2, logic [12:0] off);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
endfunction

function automatic word_t enc_u(opcode_e op, reg_idx_t rd, logic [19:0] imm);
  return {imm, rd, op};
endfunction

function automatic word_t enc_j(reg_idx_t rd, logic [20:0] off);
  return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
endfunction

task automatic emit(word_t insn);
  image[code_words] = insn;
  code_words++;
endtask

task automatic expect_store(word_t addr, byte_en_t be, word_t data);
  exp_addr[num_stores] = addr;
  exp_be[num_stores]   = be;
  exp_data[num_stores] = data;
  num_stores++;
endtask

// SW of one register to the next signature slot
task automatic store_sig(reg_idx_t rs, word_t value);
  word_t addr;
  addr = SIG_BASE + (word_t'(sig_slots) << 2);
  emit(enc_s(3'b010, 5'd0, rs, addr[11:0]));
  expect_store(addr, 4'b1111, value);
  sig_slots++;
endtask

task automatic load_const(reg_idx_t rd, word_t value);
  word_t hi;
  hi = value + 32'h800; // ADDI sign-extends the low part
  emit(enc_u(OP_LUI, rd, hi[31:12]));
  emit(enc_i(OP_IMM, 3'b000, rd, rd, value[11:0]));
endtask

task automatic poison_store();
  emit(enc_s(3'b010, 5'd0, 5'd2, 12'(POISON)));
endtask

task automatic build_program();
  word_t       a;
  word_t       b;
  word_t       va;
  word_t       vb;
  word_t       v;
  word_t       m;
  word_t       addr;
  reg_idx_t    rs_a;
  reg_idx_t    rs_b;
  logic [11:0] imm;
  for (int i = 0; i < MEM_WORDS; i++) begin
    image[i] = 32'h5a00_0000 | (word_t'(i) << 2); // Tagged with the word address
  end
  for (int r = 0; r < 2; r++) begin
    a = next_rand();
    b = next_rand();
    load_const(5'd1, a);
    load_const(5'd2, b);
    for (int f = 0; f < 8; f++) begin
      for (int s = 0; s < 2; s++) begin
        if (s == 0 || f == 0 || f == 5) begin // SUB and SRA
          emit(enc_r(funct3_t'(f), s[0], 5'd3, 5'd1, 5'd2));
          store_sig(5'd3, alu_ref(funct3_t'(f), s[0], a, b));
        end
      end
    end
    for (int f = 0; f < 8; f++) begin
      for (int s = 0; s < 2; s++) begin
        if (s == 0 || f == 5) begin
          imm = 12'(next_rand());
          if (f == 1 || f == 5) begin
            imm = {1'b0, s[0], 5'b0, imm[4:0]}; // Shift amount, bit 10 selects SRAI
          end
          emit(enc_i(OP_IMM, funct3_t'(f), 5'd3, 5'd1, imm));
          store_sig(5'd3, alu_ref(funct3_t'(f), s[0], a, {{20{imm[11]}}, imm}));
        end
      end
    end
  end

  // Each branch on (x1,x2), (x2,x1) and (x1,x1)
  for (int f = 0; f < 8; f++) begin
    if (f != 2 && f != 3) begin
      for (int p = 0; p < 3; p++) begin
        rs_a = (p == 1) ? 5'd2 : 5'd1;
        rs_b = (p == 0) ? 5'd2 : 5'd1;
        va   = (p == 1) ? b : a;
        vb   = (p == 0) ? b : a;
        emit(enc_b(funct3_t'(f), rs_a, rs_b, 13'd8));
        if (branch_ref(funct3_t'(f), va, vb)) begin
          poison_store();
        end else begin
          store_sig(5'd2, b);
        end
      end
    end
  end

  addr = word_t'(code_words) << 2;
  emit(enc_j(5'd4, 21'd8));
  poison_store();
  store_sig(5'd4, addr + 32'd4);
  addr = word_t'(code_words) << 2;
  emit(enc_u(OP_AUIPC, 5'd5, 20'd0));
  store_sig(5'd5, addr);
  emit(enc_i(OP_JALR, 3'b000, 5'd4, 5'd5, 12'd17)); // Odd target, bit 0 dropped
  poison_store();
  store_sig(5'd4, addr + 32'd12);
  v = next_rand();
  emit(enc_u(OP_LUI, 5'd6, v[19:0]));
  store_sig(5'd6, {v[19:0], 12'b0});
  addr = word_t'(code_words) << 2;
  v = next_rand();
  emit(enc_u(OP_AUIPC, 5'd6, v[31:12]));
  store_sig(5'd6, addr + {v[31:12], 12'b0});

  // Sub-word stores into scratch, then loads back
  v = next_rand() | 32'h0000_8080; // Negative byte and halfword
  load_const(5'd7, v);
  emit(enc_s(3'b010, 5'd0, 5'd7, 12'(SCRATCH)));
  expect_store(SCRATCH, 4'b1111, v);
  emit(enc_s(3'b000, 5'd0, 5'd7, 12'(SCRATCH + 1)));
  expect_store(SCRATCH, 4'b0010, {4{v[7:0]}});
  emit(enc_s(3'b001, 5'd0, 5'd7, 12'(SCRATCH + 2)));
  expect_store(SCRATCH, 4'b1100, {2{v[15:0]}});
  m = {v[15:0], v[7:0], v[7:0]};
  emit(enc_i(OP_LOAD, 3'b000, 5'd8, 5'd0, 12'(SCRATCH + 1)));
  store_sig(5'd8, {{24{m[15]}}, m[15:8]});
  emit(enc_i(OP_LOAD, 3'b100, 5'd8, 5'd0, 12'(SCRATCH + 1)));
  store_sig(5'd8, {24'b0, m[15:8]});
  emit(enc_i(OP_LOAD, 3'b001, 5'd8, 5'd0, 12'(SCRATCH + 2)));
  store_sig(5'd8, {{16{m[31]}}, m[31:16]});
  emit(enc_i(OP_LOAD, 3'b101, 5'd8, 5'd0, 12'(SCRATCH + 2)));
  store_sig(5'd8, {16'b0, m[31:16]});
  emit(enc_i(OP_LOAD, 3'b010, 5'd8, 5'd0, 12'(SCRATCH)));
  store_sig(5'd8, m);

  emit(32'h0ff0_000f); // FENCE
  emit(enc_i(OP_SYSTEM, 3'b000, 5'd0, 5'd0, 12'd0)); // ECALL
  poison_store(); // Only reached if the PC runs past ECALL
  prog_words = code_words;
endtask

`endif

// File: verif/tb_rv_core.sv
`timescale 1ns/100ps

`include "rv_core_cfg.svh"

module tb_rv_core;
  import rv_pkg::*;

  localparam int          CLK_PERIOD   = 40;
  localparam int          RESET_CYCLES = 16;
  localparam int          MEM_WORDS    = 1024;
  localparam int          MAX_STORES   = 256;
  localparam logic [31:0] LCG_SEED     = 32'd36;
  localparam logic [31:0] SIG_BASE     = 32'h0000_0400;
  localparam logic [31:0] SCRATCH      = 32'h0000_07f0;
  localparam logic [31:0] POISON       = 32'h0000_07f8; // Never a legal store target

  logic     clk = 1'b0;
  logic     rst = 1'b1;
  word_t    imem_addr;
  word_t    imem_data;
  word_t    dmem_addr;
  word_t    dmem_wdata;
  word_t    dmem_rdata;
  byte_en_t dmem_be;
  logic     halt;

  word_t    mem      [0:MEM_WORDS-1];
  word_t    image    [0:MEM_WORDS-1]; // Program image, copied in during reset
  word_t    exp_addr [0:MAX_STORES-1];
  byte_en_t exp_be   [0:MAX_STORES-1];
  word_t    exp_data [0:MAX_STORES-1];
  int       code_words = 0;
  int       prog_words = 0;
  int       sig_slots  = 0;
  int       num_stores = 0;
  int       store_idx  = 0;  // Stores seen so far
  word_t    rng_state  = LCG_SEED;
  word_t    prev_imem_addr;
  logic     prev_halt = 1'b0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  rv_core dut (
    .clk        (clk),
    .rst        (rst),
    .imem_data  (imem_data),
    .dmem_rdata (dmem_rdata),
    .imem_addr  (imem_addr),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_be    (dmem_be),
    .halt       (halt)
  );

  // Memory model, combinational read and byte writes at the edge
  assign imem_data  = mem[imem_addr[11:2]];
  assign dmem_rdata = mem[dmem_addr[11:2]];

  always @(posedge clk) begin
    if (rst) begin
      mem <= image;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (dmem_be[i]) begin
          mem[dmem_addr[11:2]][8*i +: 8] <= dmem_wdata[8*i +: 8];
        end
      end
    end
  end

  always @(posedge clk) begin
    prev_imem_addr <= imem_addr;
    prev_halt      <= halt;
    if (!rst && dmem_be != '0) begin
      store_idx <= store_idx + 1;
    end
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input word_t expected, input word_t actual);
    abort_run($sformatf("** Error: %s expected %h, actual %h", name, expected, actual));
  endtask

  function automatic word_t next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // RV32I integer operation by funct3, alt is instruction bit 30
  function automatic word_t alu_ref(funct3_t f3, logic alt, word_t a, word_t b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_ref(funct3_t f3, word_t a, word_t b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  `include "tb_program.svh"

  // Reset state, also in the first cycle after release
  assert property (@(negedge clk) (rst || $fell(rst)) |-> imem_addr == `RV_RESET_PC)
    else report_mismatch("imem_addr", `RV_RESET_PC, imem_addr);
  assert property (@(negedge clk) (rst || $fell(rst)) |-> dmem_be == '0)
    else report_mismatch("dmem_be", 32'h0, word_t'(dmem_be));
  assert property (@(negedge clk) (rst || $fell(rst)) |-> !halt)
    else abort_run("halt was raised during reset");

  // Every store must match the next entry of the expected list
  assert property (@(negedge clk) disable iff (rst) (dmem_be != '0) |-> store_idx < num_stores)
    else abort_run($sformatf("unexpected extra store to address %h", dmem_addr));
  assert property (@(negedge clk) disable iff (rst)
    (dmem_be != '0 && store_idx < num_stores) |-> dmem_addr == exp_addr[store_idx])
    else report_mismatch("dmem_addr", exp_addr[store_idx], dmem_addr);
  assert property (@(negedge clk) disable iff (rst)
    (dmem_be != '0 && store_idx < num_stores) |-> dmem_be == exp_be[store_idx])
    else report_mismatch("dmem_be", word_t'(exp_be[store_idx]), word_t'(dmem_be));
  assert property (@(negedge clk) disable iff (rst)
    (dmem_be != '0 && store_idx < num_stores) |-> dmem_wdata == exp_data[store_idx])
    else report_mismatch("dmem_wdata", exp_data[store_idx], dmem_wdata);

  // Once halted the core stays frozen
  assert property (@(negedge clk) disable iff (rst) prev_halt |-> halt)
    else abort_run("halt dropped after the ECALL");
  assert property (@(negedge clk) disable iff (rst) (halt && prev_halt) |->
    imem_addr == prev_imem_addr)
    else report_mismatch("imem_addr", prev_imem_addr, imem_addr);
  assert property (@(negedge clk) disable iff (rst) halt |-> dmem_be == '0)
    else report_mismatch("dmem_be", 32'h0, word_t'(dmem_be));

  initial begin
    build_program();
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst = 1'b0;
    while (halt !== 1'b1) begin
      @(negedge clk);
    end
    repeat (4) @(negedge clk); // Keep the halt checks running a while
    if (store_idx == num_stores) begin
      $display("Test OK");
      $finish;
    end else begin
      abort_run($sformatf("halt reached after only %0d of %0d stores", store_idx, num_stores));
    end
  end

  initial begin
    wait (prog_words != 0);
    #((2 * prog_words + RESET_CYCLES) * CLK_PERIOD);
    abort_run("halt was never reached within the time limit");
  end

endmodule

// File: rv_core.f
+incdir+hw
+incdir+verif
hw/rv_pkg.sv
hw/rv_regfile.sv
hw/rv_decoder.sv
hw/rv_alu.sv
hw/rv_lsu.sv
hw/rv_core.sv
verif/tb_rv_core.sv

// File: Makefile
VERILATOR := verilator
TOP       := tb_rv_core
FILELIST  := rv_core.f
VFLAGS    := --binary --timing --assert -j 0
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS   := $(wildcard hw/*.svh verif/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
